/* mci_cfg.svh */
////////////////////////////////////////
// MCI configuration macros
// Address map, sizes, ID value and bus widths
////////////////////////////////////////
`ifndef MCI_CFG_SVH
`define MCI_CFG_SVH

// Bus widths
`define MCI_ADDR_W 32
`define MCI_DATA_W 32

// Register region, 4 KB at the bottom of the map
`define MCI_REG_START 32'h0000_0000
`define MCI_REG_SIZE 32'h0000_1000
`define MCI_REG_END (`MCI_REG_START + `MCI_REG_SIZE - 1)

// MCU SRAM region
`define MCU_SRAM_START 32'h0002_0000
`define MCU_SRAM_SIZE_KB 4
`define MCU_SRAM_END (`MCU_SRAM_START + (`MCU_SRAM_SIZE_KB * 1024) - 1)

// Value returned by the ID register
`define MCI_HW_ID 32'h4D43_4901

`endif

/* mci_pkg.sv */
////////////////////////////////////////
// MCI shared types
// Target select, register index, AXI responses
////////////////////////////////////////
package mci_pkg;

    // Decoded target of a cif request
    typedef enum logic [1:0] {
        TGT_REG  = 2'd0,
        TGT_SRAM = 2'd1,
        TGT_MISS = 2'd2
    } mci_target_e;

    // Word offset inside the register region
    typedef enum logic [1:0] {
        // 0x0, read only
        REG_ID      = 2'd0,
        // 0x4
        REG_SCRATCH = 2'd1,
        // 0x8, bit 0 is the SRAM write lock
        REG_CTRL    = 2'd2
    } mci_reg_idx_e;

    // AXI response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

/* mci_axi_sub.sv */
////////////////////////////////////////
// AXI4-Lite subordinate front end
// One transaction at a time, turned into a
// single cif request, response held until taken
////////////////////////////////////////
`timescale 1ns/10ps
`include "mci_cfg.svh"

module mci_axi_sub
    import mci_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    // AXI write address and data
    input  logic [`MCI_ADDR_W-1:0]     awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`MCI_DATA_W-1:0]     wdata,
    input  logic [`MCI_DATA_W/8-1:0]   wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    // AXI write response
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    // AXI read
    input  logic [`MCI_ADDR_W-1:0]     araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [`MCI_DATA_W-1:0]     rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    // cif request side
    output logic                       cif_dv,
    output logic [`MCI_ADDR_W-1:0]     cif_addr,
    output logic                       cif_write,
    output logic [`MCI_DATA_W-1:0]     cif_wdata,
    output logic [`MCI_DATA_W/8-1:0]   cif_wstrb,
    input  logic [`MCI_DATA_W-1:0]     cif_rdata,
    input  logic                       cif_hold,
    input  logic                       cif_error
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_RESP
    } sub_state_e;

    sub_state_e                state;
    // AW or W taken alone, waiting for its partner
    logic                      aw_got;
    logic                      w_got;
    logic                      aw_hs;
    logic                      w_hs;
    logic                      ar_hs;
    logic                      wr_go;
    axi_resp_e                 resp_q;
    logic [`MCI_DATA_W-1:0]    rdata_q;
    // Target name for waveform viewing
    mci_target_e               dbg_target;

    ////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////
    assign awready = (state == ST_IDLE) && !aw_got;
    assign wready  = (state == ST_IDLE) && !w_got;
    // Any write activity blocks the read, so writes win
    assign arready = (state == ST_IDLE) && !aw_got && !w_got && !awvalid && !wvalid;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;
    // Both halves of the write are in
    assign wr_go = (aw_got || aw_hs) && (w_got || w_hs);

    // Request is live for the whole REQ state
    assign cif_dv = (state == ST_REQ);

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            cif_write <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_go) begin
                        state     <= ST_REQ;
                        cif_write <= 1'b1;
                        aw_got    <= 1'b0;
                        w_got     <= 1'b0;
                    end else if (ar_hs) begin
                        state     <= ST_REQ;
                        cif_write <= 1'b0;
                    end else begin
                        aw_got <= aw_got || aw_hs;
                        w_got  <= w_got || w_hs;
                    end
                end
                // Wait out target hold
                ST_REQ: begin
                    if (!cif_hold) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Payload capture
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            cif_addr <= awaddr;
        end else if (ar_hs) begin
            cif_addr <= araddr;
        end
        if (w_hs) begin
            cif_wdata <= wdata;
            cif_wstrb <= wstrb;
        end
        // Response sampled on the completing cycle
        if (cif_dv && !cif_hold) begin
            resp_q  <= cif_error ? RESP_SLVERR : RESP_OKAY;
            rdata_q <= cif_rdata;
        end
    end

    // Response channels
    assign bvalid = (state == ST_RESP) && cif_write;
    assign rvalid = (state == ST_RESP) && !cif_write;
    assign bresp  = resp_q;
    assign rresp  = resp_q;
    assign rdata  = rdata_q;

    // Debug decode of the current address
    always_comb begin
        if (cif_addr inside {[`MCI_REG_START:`MCI_REG_END]}) begin
            dbg_target = TGT_REG;
        end else if (cif_addr inside {[`MCU_SRAM_START:`MCU_SRAM_END]}) begin
            dbg_target = TGT_SRAM;
        end else begin
            dbg_target = TGT_MISS;
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////
    // Held request keeps all its fields
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        cif_dv && cif_hold |=>
            cif_dv && $stable({cif_addr, cif_write, cif_wdata, cif_wstrb}))
        else $error("cif request changed under hold");

    // Miss ends at once with error from the decoder
    a_miss_done: assert property (@(posedge clk) disable iff (!arst_n)
        cif_dv && (dbg_target == TGT_MISS) |-> cif_error && !cif_hold)
        else $error("unmapped request not rejected");

endmodule

/* mci_axi_sub_decode.sv */
////////////////////////////////////////
// cif address decoder
// Routes requests to registers or SRAM,
// rejects misses with error
////////////////////////////////////////
`timescale 1ns/10ps
`include "mci_cfg.svh"

module mci_axi_sub_decode
    import mci_pkg::*;
(
    // Request from the subordinate
    input  logic                       cif_dv,
    input  logic [`MCI_ADDR_W-1:0]     cif_addr,
    input  logic                       cif_write,
    input  logic [`MCI_DATA_W-1:0]     cif_wdata,
    input  logic [`MCI_DATA_W/8-1:0]   cif_wstrb,
    output logic [`MCI_DATA_W-1:0]     cif_rdata,
    output logic                       cif_hold,
    output logic                       cif_error,
    // Register block
    output logic                       reg_dv,
    output logic [`MCI_ADDR_W-1:0]     reg_addr,
    output logic                       reg_write,
    output logic [`MCI_DATA_W-1:0]     reg_wdata,
    output logic [`MCI_DATA_W/8-1:0]   reg_wstrb,
    input  logic [`MCI_DATA_W-1:0]     reg_rdata,
    input  logic                       reg_error,
    // MCU SRAM
    output logic                       sram_dv,
    output logic [`MCI_ADDR_W-1:0]     sram_addr,
    output logic                       sram_write,
    output logic [`MCI_DATA_W-1:0]     sram_wdata,
    output logic [`MCI_DATA_W/8-1:0]   sram_wstrb,
    input  logic [`MCI_DATA_W-1:0]     sram_rdata,
    input  logic                       sram_hold,
    input  logic                       sram_error
);

    logic        reg_gnt;
    logic        sram_gnt;
    logic        req_miss;
    mci_target_e tgt;

    ////////////////////////////////////////
    // Region compare and grants
    ////////////////////////////////////////
    assign reg_gnt  = cif_dv && (cif_addr inside {[`MCI_REG_START:`MCI_REG_END]});
    assign sram_gnt = cif_dv && (cif_addr inside {[`MCU_SRAM_START:`MCU_SRAM_END]});
    assign req_miss = cif_dv && !reg_gnt && !sram_gnt;

    // Only the hit target sees dv
    assign reg_dv  = reg_gnt;
    assign sram_dv = sram_gnt;

    // Request fields fan out to both
    assign reg_addr   = cif_addr;
    assign reg_write  = cif_write;
    assign reg_wdata  = cif_wdata;
    assign reg_wstrb  = cif_wstrb;
    assign sram_addr  = cif_addr;
    assign sram_write = cif_write;
    assign sram_wdata = cif_wdata;
    assign sram_wstrb = cif_wstrb;

    ////////////////////////////////////////
    // Return path
    ////////////////////////////////////////
    // Selected target for the return mux
    always_comb begin
        if (sram_gnt) begin
            tgt = TGT_SRAM;
        end else if (reg_gnt) begin
            tgt = TGT_REG;
        end else begin
            tgt = TGT_MISS;
        end
        // Overlapping regions would grant both
        if (cif_dv) begin
            assert (!(reg_gnt && sram_gnt))
                else $error("decoder grant conflict");
        end
    end

    assign cif_rdata = (tgt == TGT_SRAM) ? sram_rdata :
                       (tgt == TGT_REG)  ? reg_rdata  :
                       '0;

    // Registers never hold
    assign cif_hold = (tgt == TGT_SRAM) && sram_hold;

    // Miss completes at once with error
    assign cif_error = ((tgt == TGT_SRAM) && sram_error) ||
                       ((tgt == TGT_REG) && reg_error) || req_miss;

endmodule

/* mci_reg.sv */
////////////////////////////////////////
// MCI register block
// ID, scratch and control registers,
// control bit 0 locks SRAM writes
////////////////////////////////////////
`timescale 1ns/10ps
`include "mci_cfg.svh"

module mci_reg
    import mci_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       reg_dv,
    input  logic [`MCI_ADDR_W-1:0]     reg_addr,
    input  logic                       reg_write,
    input  logic [`MCI_DATA_W-1:0]     reg_wdata,
    input  logic [`MCI_DATA_W/8-1:0]   reg_wstrb,
    output logic [`MCI_DATA_W-1:0]     reg_rdata,
    output logic                       reg_error,
    output logic                       sram_wr_lock
);

    mci_reg_idx_e             idx;
    logic                     off_valid;
    logic                     wr_en;
    logic [`MCI_DATA_W-1:0]   scratch;

    ////////////////////////////////////////
    // Offset decode
    ////////////////////////////////////////
    assign idx = mci_reg_idx_e'(reg_addr[3:2]);

    // Only the first three words exist
    assign off_valid = (reg_addr[11:4] == '0) && (reg_addr[3:2] != 2'd3);

    assign wr_en = reg_dv && reg_write && off_valid;

    // ID is read only, holes are rejected
    assign reg_error = reg_dv && (!off_valid || (reg_write && (idx == REG_ID)));

    ////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scratch      <= '0;
            sram_wr_lock <= 1'b0;
        end else if (wr_en) begin
            case (idx)
                REG_SCRATCH: begin
                    // Byte merge
                    for (int b = 0; b < `MCI_DATA_W/8; b++) begin
                        if (reg_wstrb[b]) begin
                            scratch[b*8 +: 8] <= reg_wdata[b*8 +: 8];
                        end
                    end
                end
                REG_CTRL: begin
                    if (reg_wstrb[0]) begin
                        sram_wr_lock <= reg_wdata[0];
                    end
                end
                // ID write ignored, error already raised
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////
    always_comb begin
        reg_rdata = '0;
        if (off_valid) begin
            case (idx)
                REG_ID:      reg_rdata = `MCI_HW_ID;
                REG_SCRATCH: reg_rdata = scratch;
                // Upper CTRL bits read as zero
                REG_CTRL:    reg_rdata = {{(`MCI_DATA_W-1){1'b0}}, sram_wr_lock};
                default:     reg_rdata = '0;
            endcase
        end
    end

endmodule

/* mcu_sram.sv */
////////////////////////////////////////
// MCU SRAM
// Byte-strobed word memory, registered read
// with one hold cycle, honours the write lock
////////////////////////////////////////
`timescale 1ns/10ps
`include "mci_cfg.svh"

module mcu_sram (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       sram_dv,
    input  logic [`MCI_ADDR_W-1:0]     sram_addr,
    input  logic                       sram_write,
    input  logic [`MCI_DATA_W-1:0]     sram_wdata,
    input  logic [`MCI_DATA_W/8-1:0]   sram_wstrb,
    input  logic                       sram_wr_lock,
    output logic [`MCI_DATA_W-1:0]     sram_rdata,
    output logic                       sram_hold,
    output logic                       sram_error
);

    localparam int DEPTH = (`MCU_SRAM_SIZE_KB * 1024) / (`MCI_DATA_W / 8);
    localparam int IDX_W = $clog2(DEPTH);

    logic [`MCI_DATA_W-1:0] mem [DEPTH];
    logic [`MCI_ADDR_W-1:0] offset;
    logic [IDX_W-1:0]       word_idx;
    logic                   rd_start;
    // Read data valid next cycle
    logic                   rd_pend;

    // Word index from the region base
    assign offset   = sram_addr - `MCU_SRAM_START;
    assign word_idx = offset[IDX_W+1:2];

    // First cycle of a read
    assign rd_start = sram_dv && !sram_write && !rd_pend;

    assign sram_hold = rd_start;

    // Locked writes rejected
    assign sram_error = sram_dv && sram_write && sram_wr_lock;

    ////////////////////////////////////////
    // Read pipeline
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= rd_start;
        end
    end

    ////////////////////////////////////////
    // Memory array
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (sram_dv && sram_write && !sram_wr_lock) begin
            for (int b = 0; b < `MCI_DATA_W/8; b++) begin
                if (sram_wstrb[b]) begin
                    mem[word_idx][b*8 +: 8] <= sram_wdata[b*8 +: 8];
                end
            end
        end
        if (rd_start) begin
            sram_rdata <= mem[word_idx];
        end
    end

    // Read under hold stays a read of the same word, no write slips in
    a_hold_read: assert property (@(posedge clk) disable iff (!arst_n)
        sram_hold |=> sram_dv && !sram_write && $stable(sram_addr))
        else $error("SRAM request changed during the read wait");

endmodule

/* mci_top.sv */
////////////////////////////////////////
// MCI subsystem top
// AXI4-Lite front end, decoder, registers, SRAM
////////////////////////////////////////
`timescale 1ns/10ps
`include "mci_cfg.svh"

module mci_top (
    input  logic                       clk,
    input  logic                       arst_n,
    // AXI4-Lite write
    input  logic [`MCI_ADDR_W-1:0]     awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`MCI_DATA_W-1:0]     wdata,
    input  logic [`MCI_DATA_W/8-1:0]   wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    // AXI4-Lite read
    input  logic [`MCI_ADDR_W-1:0]     araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [`MCI_DATA_W-1:0]     rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);

    // Subordinate to decoder
    logic                       cif_dv;
    logic [`MCI_ADDR_W-1:0]     cif_addr;
    logic                       cif_write;
    logic [`MCI_DATA_W-1:0]     cif_wdata;
    logic [`MCI_DATA_W/8-1:0]   cif_wstrb;
    logic [`MCI_DATA_W-1:0]     cif_rdata;
    logic                       cif_hold;
    logic                       cif_error;

    // Decoder to register block
    logic                       reg_dv;
    logic [`MCI_ADDR_W-1:0]     reg_addr;
    logic                       reg_write;
    logic [`MCI_DATA_W-1:0]     reg_wdata;
    logic [`MCI_DATA_W/8-1:0]   reg_wstrb;
    logic [`MCI_DATA_W-1:0]     reg_rdata;
    logic                       reg_error;

    // Decoder to SRAM
    logic                       sram_dv;
    logic [`MCI_ADDR_W-1:0]     sram_addr;
    logic                       sram_write;
    logic [`MCI_DATA_W-1:0]     sram_wdata;
    logic [`MCI_DATA_W/8-1:0]   sram_wstrb;
    logic [`MCI_DATA_W-1:0]     sram_rdata;
    logic                       sram_hold;
    logic                       sram_error;

    // Lock from CTRL into the SRAM
    logic                       sram_wr_lock;

    // Port names match across the tree
    mci_axi_sub        i_axi_sub (.*);
    mci_axi_sub_decode i_decode  (.*);
    mci_reg            i_reg     (.*);
    mcu_sram           i_sram    (.*);

endmodule

/* tb_mci_tasks.svh */
////////////////////////////////////////
// AXI4-Lite driver tasks and reference model
// Included inside the testbench module
////////////////////////////////////////
`ifndef TB_MCI_TASKS_SVH
`define TB_MCI_TASKS_SVH

////////////////////////////////////////
// Reference model state
////////////////////////////////////////
logic [`MCI_DATA_W-1:0] model_sram [SRAM_WIN];
logic [`MCI_DATA_W-1:0] model_scratch;
logic                   model_lock;

// Strobed bytes from the new word, rest from the old
function automatic logic [`MCI_DATA_W-1:0] merge_bytes(
    input logic [`MCI_DATA_W-1:0]   old_word,
    input logic [`MCI_DATA_W-1:0]   new_word,
    input logic [`MCI_DATA_W/8-1:0] strb
);
    logic [`MCI_DATA_W-1:0] mask;
    int                     b;
    mask = '0;
    for (b = 0; b < `MCI_DATA_W/8; b++) begin
        mask[b*8 +: 8] = {8{strb[b]}};
    end
    return (old_word & ~mask) | (new_word & mask);
endfunction

// Initial SRAM contents, every address bit matters
function automatic logic [`MCI_DATA_W-1:0] fill_word(input logic [`MCI_ADDR_W-1:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
endfunction

// Byte address of a register word
function automatic logic [`MCI_ADDR_W-1:0] reg_word_addr(input mci_reg_idx_e idx);
    return `MCI_REG_START + (32'(idx) << 2);
endfunction

////////////////////////////////////////
// Response phase
////////////////////////////////////////
// Back-pressure for a while, response must not move, then accept it
task automatic hold_response(
    input bit                     is_write,
    input int                     delay,
    input logic [1:0]             resp_seen,
    input logic [`MCI_DATA_W-1:0] data_seen
);
    int d;
    for (d = 0; d < delay; d++) begin
        @(posedge clk);
        check_count++;
        if (is_write && (!bvalid || bresp !== resp_seen)) begin
            err_count++;
            $display("Error at %0t ns: write response changed before bready", $time);
        end
        if (!is_write && (!rvalid || rresp !== resp_seen || rdata !== data_seen)) begin
            err_count++;
            $display("Error at %0t ns: read response changed before rready", $time);
        end
        // No new address while the response waits
        if (awready || wready || arready) begin
            err_count++;
            $display("Error at %0t ns: ready high while a response is pending", $time);
        end
    end
    if (is_write) begin
        bready <= 1'b1;
    end else begin
        rready <= 1'b1;
    end
    @(posedge clk);
    bready <= 1'b0;
    rready <= 1'b0;
endtask

////////////////////////////////////////
// Transactions
////////////////////////////////////////
task automatic axi_write(
    input  logic [`MCI_ADDR_W-1:0]   addr,
    input  logic [`MCI_DATA_W-1:0]   data,
    input  logic [`MCI_DATA_W/8-1:0] strb,
    input  int                       exp_lat,
    input  int                       delay,
    output logic [1:0]               resp
);
    int lat;
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    // AW and W go in on the same edge
    do begin
        @(posedge clk);
    end while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    lat = 0;
    do begin
        @(posedge clk);
        lat++;
    end while (!bvalid);
    resp = bresp;
    check_count++;
    if (lat != exp_lat) begin
        err_count++;
        $display("Error at %0t ns: write to %h took %0d cycles, expected %0d",
                 $time, addr, lat, exp_lat);
    end
    hold_response(1'b1, delay, resp, '0);
endtask

task automatic axi_read(
    input  logic [`MCI_ADDR_W-1:0] addr,
    input  int                     exp_lat,
    input  int                     delay,
    output logic [1:0]             resp,
    output logic [`MCI_DATA_W-1:0] data
);
    int lat;
    araddr  <= addr;
    arvalid <= 1'b1;
    do begin
        @(posedge clk);
    end while (!arready);
    arvalid <= 1'b0;
    lat = 0;
    do begin
        @(posedge clk);
        lat++;
    end while (!rvalid);
    resp = rresp;
    data = rdata;
    check_count++;
    if (lat != exp_lat) begin
        err_count++;
        $display("Error at %0t ns: read of %h took %0d cycles, expected %0d",
                 $time, addr, lat, exp_lat);
    end
    hold_response(1'b0, delay, resp, data);
endtask

`endif

/* tb_mci.sv */
////////////////////////////////////////
// MCI subsystem testbench
// Random AXI4-Lite traffic against a model
////////////////////////////////////////
`timescale 1ns/10ps
`include "mci_cfg.svh"

module tb_mci
    import mci_pkg::*;
();

    localparam int N_OPS        = 400;
    // SRAM words that random traffic touches
    localparam int SRAM_WIN     = 32;
    localparam int WATCH_CYCLES = (N_OPS + SRAM_WIN + 8) * 20;

    logic                     clk;
    logic                     arst_n;
    logic [`MCI_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [`MCI_DATA_W-1:0]   wdata;
    logic [`MCI_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [`MCI_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [`MCI_DATA_W-1:0]   rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;

    int seed        = 89657;
    int err_count   = 0;
    int check_count = 0;

    mci_top i_dut (.*);

    `include "tb_mci_tasks.svh"

    // Uniform draw in [0, range)
    function automatic int unsigned draw_below(input int unsigned range);
        return $unsigned($random(seed)) % range;
    endfunction

    // 100 ns clock
    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////
    initial begin
        #(WATCH_CYCLES * 100);
        $display("Timeout: run did not finish within %0d cycles", WATCH_CYCLES);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////
    initial begin
        int                       n;
        int                       w;
        int unsigned              kind;
        bit                       is_wr;
        int                       exp_lat;
        int                       delay;
        logic [`MCI_ADDR_W-1:0]   addr;
        logic [`MCI_DATA_W-1:0]   data;
        logic [`MCI_DATA_W-1:0]   exp_data;
        logic [`MCI_DATA_W-1:0]   got_data;
        logic [`MCI_DATA_W/8-1:0] strb;
        logic [1:0]               got_resp;
        axi_resp_e                exp_resp;

        clk     = 1'b0;
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        model_scratch = '0;
        model_lock    = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // Known contents in the SRAM window, lock is clear after reset
        for (w = 0; w < SRAM_WIN; w++) begin
            addr = `MCU_SRAM_START + 32'(w * 4);
            data = fill_word(addr);
            axi_write(addr, data, 4'hF, 2, 0, got_resp);
            check_count++;
            if (got_resp !== RESP_OKAY) begin
                err_count++;
                $display("Error at %0t ns: SRAM fill at %h got resp %0d", $time, addr, got_resp);
            end
            model_sram[w] = data;
        end

        for (n = 0; n < N_OPS; n++) begin
            kind     = draw_below(7);
            is_wr    = (draw_below(2) == 1);
            data     = $random(seed);
            strb     = 4'(draw_below(16));
            delay    = int'(draw_below(8));
            w        = int'(draw_below(SRAM_WIN));
            exp_resp = RESP_OKAY;
            exp_data = '0;
            exp_lat  = 2;
            // Expected values taken before the model moves
            case (kind)
                0: begin
                    addr     = reg_word_addr(REG_ID);
                    exp_data = `MCI_HW_ID;
                    if (is_wr) begin
                        exp_resp = RESP_SLVERR;
                    end
                end
                1: begin
                    addr     = reg_word_addr(REG_SCRATCH);
                    exp_data = model_scratch;
                    if (is_wr) begin
                        model_scratch = merge_bytes(model_scratch, data, strb);
                    end
                end
                2: begin
                    addr     = reg_word_addr(REG_CTRL);
                    exp_data = {{(`MCI_DATA_W-1){1'b0}}, model_lock};
                    if (is_wr && strb[0]) begin
                        model_lock = data[0];
                    end
                end
                3: begin
                    // Holes above CTRL
                    addr     = `MCI_REG_START + 32'h0C + 32'(draw_below(1021) * 4);
                    exp_resp = RESP_SLVERR;
                end
                4, 5: begin
                    addr     = `MCU_SRAM_START + 32'(w * 4);
                    exp_data = model_sram[w];
                    if (!is_wr) begin
                        exp_lat = 3;
                    end else if (model_lock) begin
                        exp_resp = RESP_SLVERR;
                    end else begin
                        model_sram[w] = merge_bytes(model_sram[w], data, strb);
                    end
                end
                default: begin
                    // Gap between the regions, or far above the SRAM
                    addr = (data[31] ? 32'h8000_0000 : 32'h0001_0000) |
                           (32'(draw_below(32'h1_0000)) & 32'h0000_FFFC);
                    exp_resp = RESP_SLVERR;
                end
            endcase

            if (is_wr) begin
                axi_write(addr, data, strb, exp_lat, delay, got_resp);
            end else begin
                axi_read(addr, exp_lat, delay, got_resp, got_data);
                check_count++;
                if (got_data !== exp_data) begin
                    err_count++;
                    $display("Error at %0t ns: read of %h returned %h, expected %h",
                             $time, addr, got_data, exp_data);
                end
            end
            check_count++;
            if (got_resp !== exp_resp) begin
                err_count++;
                $display("Error at %0t ns: %s %h got resp %0d, expected %0d", $time,
                         is_wr ? "write" : "read", addr, got_resp, exp_resp);
            end
        end

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
mci_pkg.sv
mci_axi_sub.sv
mci_axi_sub_decode.sv
mci_reg.sv
mcu_sram.sv
mci_top.sv
tb_mci.sv

/* Makefile */
# Verilator build and run of the MCI subsystem testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_mci
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
